//--- verilog/lsu_iq_pkg.sv
package lsu_iq_pkg;

    localparam int lsu_queue_len   = 8;
    localparam int lsu_queue_idx_w = 4;   // tail count, 0..8
    localparam int lsu_sel_w       = 3;
    localparam int prf_num         = 64;

    typedef logic [$clog2(prf_num)-1:0] preg_t;

    // renamed load/store micro-op
    typedef struct packed {
        logic [7:0] id;
        logic       is_store;
        preg_t      src0;      // address base
        preg_t      src1;      // store data / index
        preg_t      dst;
        logic       has_dst;
    } lsu_uop_t;

    typedef struct packed {
        logic     valid;
        lsu_uop_t uop;
        logic     src0_rdy;
        logic     src1_rdy;
    } lsu_entry_t;

    // priority inside a slot is enq_en, then shift_en, then hold
    typedef struct packed {
        logic enq_en;
        logic enq_sel;    // 0 takes dispatch port 0
        logic shift_en;
    } slot_ctrl_t;

endpackage

//--- verilog/lsu_iq_entry.sv
`timescale 1ns/1ps

module lsu_iq_entry (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  lsu_iq_pkg::slot_ctrl_t ctrl,
    input  lsu_iq_pkg::lsu_entry_t din_0,
    input  lsu_iq_pkg::lsu_entry_t din_1,
    input  lsu_iq_pkg::lsu_entry_t above,
    input  logic                   busy_src0,
    input  logic                   busy_src1,
    output lsu_iq_pkg::lsu_entry_t cur
);

    lsu_iq_pkg::lsu_entry_t enq_data;
    lsu_iq_pkg::lsu_entry_t held;
    lsu_iq_pkg::lsu_entry_t nxt;

    assign enq_data = ctrl.enq_sel ? din_1 : din_0;

    // own content picks up wakeups from the lookup of its own sources
    always_comb begin
        held          = cur;
        held.src0_rdy = cur.src0_rdy | ~busy_src0;
        held.src1_rdy = cur.src1_rdy | ~busy_src1;
    end

    // the entry coming from above arrives already refreshed by its old slot
    always_comb begin
        if (ctrl.enq_en) begin
            nxt = enq_data;
        end else if (ctrl.shift_en) begin
            nxt = above;
        end else begin
            nxt = held;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur <= '0;
        end else if (flush) begin
            cur <= '0;
        end else begin
            cur <= nxt;
        end
    end

endmodule

//--- verilog/lsu_iq.sv
`timescale 1ns/1ps

module lsu_iq (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic                                            flush,
    input  logic                                            enq_req_0,
    input  logic                                            enq_req_1,
    input  lsu_iq_pkg::lsu_entry_t                          din_0,
    input  lsu_iq_pkg::lsu_entry_t                          din_1,
    input  logic                                            deq_en,
    input  logic [lsu_iq_pkg::lsu_sel_w-1:0]                deq_idx,
    input  logic [lsu_iq_pkg::lsu_queue_len-1:0]            src_busy_0,
    input  logic [lsu_iq_pkg::lsu_queue_len-1:0]            src_busy_1,
    output lsu_iq_pkg::lsu_uop_t                            head_uop,
    output lsu_iq_pkg::preg_t [lsu_iq_pkg::lsu_queue_len-1:0] src_l,
    output lsu_iq_pkg::preg_t [lsu_iq_pkg::lsu_queue_len-1:0] src_r,
    output logic [lsu_iq_pkg::lsu_queue_len-1:0]            valid_vec,
    output logic [lsu_iq_pkg::lsu_queue_len-1:0]            ready_vec,
    output logic [lsu_iq_pkg::lsu_queue_len-1:0]            store_vec,
    output logic                                            ready
);

    logic [lsu_iq_pkg::lsu_queue_idx_w-1:0] tail;
    logic [lsu_iq_pkg::lsu_queue_idx_w-1:0] wr_pos_0;
    logic [lsu_iq_pkg::lsu_queue_idx_w-1:0] wr_pos_1;
    logic                                   freeze;
    logic                                   acc_0;
    logic                                   acc_1;

    lsu_iq_pkg::lsu_entry_t cur   [lsu_iq_pkg::lsu_queue_len];
    lsu_iq_pkg::lsu_entry_t above [lsu_iq_pkg::lsu_queue_len];
    lsu_iq_pkg::slot_ctrl_t ctrl  [lsu_iq_pkg::lsu_queue_len];

    // one spare slot kept so a pair from dispatch always fits
    assign freeze = tail >= lsu_iq_pkg::lsu_queue_idx_w'(lsu_iq_pkg::lsu_queue_len - 1);
    assign ready  = ~freeze;
    assign acc_0  = enq_req_0 & ~freeze;
    assign acc_1  = enq_req_1 & ~freeze;

    // write positions after this cycle's collapse
    assign wr_pos_0 = tail - lsu_iq_pkg::lsu_queue_idx_w'(deq_en);
    assign wr_pos_1 = wr_pos_0 + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail <= '0;
        end else if (flush) begin
            tail <= '0;
        end else begin
            tail <= tail + lsu_iq_pkg::lsu_queue_idx_w'(acc_0)
                         + lsu_iq_pkg::lsu_queue_idx_w'(acc_1)
                         - lsu_iq_pkg::lsu_queue_idx_w'(deq_en);
        end
    end

    for (genvar i = 0; i < lsu_iq_pkg::lsu_queue_len; i++) begin : g_slot
        localparam logic [lsu_iq_pkg::lsu_queue_idx_w-1:0] slot_pos = i;

        assign ctrl[i].enq_en   = (acc_0 && wr_pos_0 == slot_pos) ||
                                  (acc_1 && wr_pos_1 == slot_pos);
        assign ctrl[i].enq_sel  = acc_1 && wr_pos_1 == slot_pos;
        assign ctrl[i].shift_en = deq_en && slot_pos[lsu_iq_pkg::lsu_sel_w-1:0] >= deq_idx;

        if (i == lsu_iq_pkg::lsu_queue_len - 1) begin : g_last
            assign above[i] = '0;
        end else begin : g_mid
            assign above[i] = '{valid:    cur[i+1].valid,
                                uop:      cur[i+1].uop,
                                src0_rdy: cur[i+1].src0_rdy | ~src_busy_0[i+1],
                                src1_rdy: cur[i+1].src1_rdy | ~src_busy_1[i+1]};
        end

        lsu_iq_entry i_lsu_iq_entry (
            .clk       (clk),
            .arst_n    (arst_n),
            .flush     (flush),
            .ctrl      (ctrl[i]),
            .din_0     (din_0),
            .din_1     (din_1),
            .above     (above[i]),
            .busy_src0 (src_busy_0[i]),
            .busy_src1 (src_busy_1[i]),
            .cur       (cur[i])
        );

        assign src_l[i]     = cur[i].uop.src0;
        assign src_r[i]     = cur[i].uop.src1;
        assign valid_vec[i] = cur[i].valid;
        assign ready_vec[i] = cur[i].src0_rdy & cur[i].src1_rdy;
        assign store_vec[i] = cur[i].uop.is_store;
    end

    assign head_uop = cur[deq_idx].uop;

endmodule

//--- verilog/lsu_issue_pick.sv
`timescale 1ns/1ps

module lsu_issue_pick (
    input  logic [lsu_iq_pkg::lsu_queue_len-1:0] valid_vec,
    input  logic [lsu_iq_pkg::lsu_queue_len-1:0] ready_vec,
    input  logic [lsu_iq_pkg::lsu_queue_len-1:0] store_vec,
    input  logic                                 lsu_busy,
    output logic [lsu_iq_pkg::lsu_sel_w-1:0]     sel,
    output logic                                 sel_valid
);

    logic [lsu_iq_pkg::lsu_queue_len-1:0] store_mask;
    logic [lsu_iq_pkg::lsu_queue_len-1:0] elig;

    // slot allowed only with no valid store below it
    always_comb begin
        store_mask[0] = 1'b1;
        for (int i = 1; i < lsu_iq_pkg::lsu_queue_len; i++) begin
            store_mask[i] = store_mask[i-1] & ~(valid_vec[i-1] & store_vec[i-1]);
        end
    end

    assign elig = valid_vec & ready_vec & store_mask &
                  {lsu_iq_pkg::lsu_queue_len{~lsu_busy}};

    // oldest first
    always_comb begin
        sel = '0;
        for (int i = lsu_iq_pkg::lsu_queue_len - 1; i >= 0; i--) begin
            if (elig[i]) begin
                sel = lsu_iq_pkg::lsu_sel_w'(i);
            end
        end
    end

    assign sel_valid = |elig;

endmodule

//--- verilog/lsu_busy_table.sv
`timescale 1ns/1ps

module lsu_busy_table (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  logic                                              set_en_0,
    input  logic                                              set_en_1,
    input  lsu_iq_pkg::preg_t                                 set_preg_0,
    input  lsu_iq_pkg::preg_t                                 set_preg_1,
    input  logic                                              clr_en_0,
    input  logic                                              clr_en_1,
    input  lsu_iq_pkg::preg_t                                 clr_preg_0,
    input  lsu_iq_pkg::preg_t                                 clr_preg_1,
    input  lsu_iq_pkg::preg_t [lsu_iq_pkg::lsu_queue_len+1:0] rd_l,
    input  lsu_iq_pkg::preg_t [lsu_iq_pkg::lsu_queue_len+1:0] rd_r,
    output logic [lsu_iq_pkg::lsu_queue_len+1:0]              busy_l,
    output logic [lsu_iq_pkg::lsu_queue_len+1:0]              busy_r
);

    logic [lsu_iq_pkg::prf_num-1:0] busy_q;
    logic [lsu_iq_pkg::prf_num-1:0] busy_nxt;

    // clears first so a set to the same register wins
    always_comb begin
        busy_nxt = busy_q;
        if (clr_en_0) busy_nxt[clr_preg_0] = 1'b0;
        if (clr_en_1) busy_nxt[clr_preg_1] = 1'b0;
        if (set_en_0) busy_nxt[set_preg_0] = 1'b1;
        if (set_en_1) busy_nxt[set_preg_1] = 1'b1;
        busy_nxt[0] = 1'b0;   // p0 is the zero register
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_nxt;
        end
    end

    for (genvar k = 0; k < lsu_iq_pkg::lsu_queue_len + 2; k++) begin : g_rd
        assign busy_l[k] = busy_q[rd_l[k]];
        assign busy_r[k] = busy_q[rd_r[k]];
    end

endmodule

//--- verilog/lsu_issue_unit.sv
`timescale 1ns/1ps

module lsu_issue_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 enq_req_0,
    input  logic                 enq_req_1,
    input  lsu_iq_pkg::lsu_uop_t enq_uop_0,
    input  lsu_iq_pkg::lsu_uop_t enq_uop_1,
    input  logic                 wb_en_0,
    input  logic                 wb_en_1,
    input  lsu_iq_pkg::preg_t    wb_preg_0,
    input  lsu_iq_pkg::preg_t    wb_preg_1,
    input  logic                 lsu_busy,
    output logic                 issue_valid,
    output lsu_iq_pkg::lsu_uop_t issue_uop,
    output logic                 ready
);

    localparam int qlen = lsu_iq_pkg::lsu_queue_len;

    lsu_iq_pkg::preg_t [qlen+1:0] src_l;
    lsu_iq_pkg::preg_t [qlen+1:0] src_r;
    logic [qlen+1:0]              busy_l;
    logic [qlen+1:0]              busy_r;

    lsu_iq_pkg::lsu_entry_t              din_0;
    lsu_iq_pkg::lsu_entry_t              din_1;
    logic [qlen-1:0]                     valid_vec;
    logic [qlen-1:0]                     ready_vec;
    logic [qlen-1:0]                     store_vec;
    logic [lsu_iq_pkg::lsu_sel_w-1:0]    sel;
    logic                                sel_valid;

    // dispatch lookups ride on the last two read ports
    assign src_l[qlen]   = enq_uop_0.src0;
    assign src_r[qlen]   = enq_uop_0.src1;
    assign src_l[qlen+1] = enq_uop_1.src0;
    assign src_r[qlen+1] = enq_uop_1.src1;

    always_comb begin
        din_0          = '0;
        din_0.valid    = 1'b1;
        din_0.uop      = enq_uop_0;
        din_0.src0_rdy = ~busy_l[qlen];
        din_0.src1_rdy = ~busy_r[qlen];
        din_1          = '0;
        din_1.valid    = 1'b1;
        din_1.uop      = enq_uop_1;
        din_1.src0_rdy = ~busy_l[qlen+1];
        din_1.src1_rdy = ~busy_r[qlen+1];
    end

    lsu_busy_table i_lsu_busy_table (
        .clk        (clk),
        .arst_n     (arst_n),
        .set_en_0   (enq_req_0 & ready & enq_uop_0.has_dst),
        .set_en_1   (enq_req_1 & ready & enq_uop_1.has_dst),
        .set_preg_0 (enq_uop_0.dst),
        .set_preg_1 (enq_uop_1.dst),
        .clr_en_0   (wb_en_0),
        .clr_en_1   (wb_en_1),
        .clr_preg_0 (wb_preg_0),
        .clr_preg_1 (wb_preg_1),
        .rd_l       (src_l),
        .rd_r       (src_r),
        .busy_l     (busy_l),
        .busy_r     (busy_r)
    );

    lsu_iq i_lsu_iq (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .enq_req_0  (enq_req_0),
        .enq_req_1  (enq_req_1),
        .din_0      (din_0),
        .din_1      (din_1),
        .deq_en     (sel_valid),
        .deq_idx    (sel),
        .src_busy_0 (busy_l[qlen-1:0]),
        .src_busy_1 (busy_r[qlen-1:0]),
        .head_uop   (issue_uop),
        .src_l      (src_l[qlen-1:0]),
        .src_r      (src_r[qlen-1:0]),
        .valid_vec  (valid_vec),
        .ready_vec  (ready_vec),
        .store_vec  (store_vec),
        .ready      (ready)
    );

    lsu_issue_pick i_lsu_issue_pick (
        .valid_vec (valid_vec),
        .ready_vec (ready_vec),
        .store_vec (store_vec),
        .lsu_busy  (lsu_busy),
        .sel       (sel),
        .sel_valid (sel_valid)
    );

    assign issue_valid = sel_valid;

endmodule

//--- tb/lsu_issue_unit_checker.sv
`timescale 1ns/1ps

module lsu_issue_unit_checker (
    input logic clk,
    input logic arst_n,
    input logic flush,
    input logic lsu_busy,
    input logic issue_valid,
    input logic ready
);

    // pipe back-pressure blocks every issue
    property no_issue_when_busy;
        @(posedge clk) disable iff (!arst_n) lsu_busy |-> !issue_valid;
    endproperty

    property empty_after_flush;
        @(posedge clk) disable iff (!arst_n) flush |=> !issue_valid;
    endproperty

    property ready_after_reset;
        @(posedge clk) $rose(arst_n) |-> ready;
    endproperty

    a_no_issue_when_busy: assert property (no_issue_when_busy)
        else $error("issue_valid high while lsu_busy is high");
    a_empty_after_flush: assert property (empty_after_flush)
        else $error("issue_valid high in the cycle after flush");
    a_ready_after_reset: assert property (ready_after_reset)
        else $error("ready low after reset release");

endmodule

bind lsu_issue_unit lsu_issue_unit_checker i_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .lsu_busy    (lsu_busy),
    .issue_valid (issue_valid),
    .ready       (ready)
);

//--- tb/lsu_issue_unit_tb.sv
`timescale 1ns/1ps

module lsu_issue_unit_tb;

    logic clk, arst_n, flush, enq_req_0, enq_req_1, wb_en_0, wb_en_1, lsu_busy;
    lsu_iq_pkg::lsu_uop_t enq_uop_0, enq_uop_1, issue_uop;
    lsu_iq_pkg::preg_t    wb_preg_0, wb_preg_1;
    logic                 issue_valid, ready;

    lsu_iq_pkg::lsu_entry_t mq[$];          // model queue in age order
    logic [lsu_iq_pkg::prf_num-1:0] mbusy;
    logic [7:0] issued_ids[$];
    logic       exp_valid;
    int         exp_idx;
    int         errors = 0;
    int         timeouts = 0;
    logic [31:0] rng = 32'h4b4b93af;
    string      cur_test = "reset";

    lsu_issue_unit i_lsu_issue_unit (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic lsu_iq_pkg::preg_t free_reg();
        lsu_iq_pkg::preg_t r;
        do begin
            rng = xorshift32(rng);
            r   = lsu_iq_pkg::preg_t'(rng);
        end while (mbusy[r] || r < 32);   // low half kept for producers
        return r;
    endfunction

    function automatic lsu_iq_pkg::lsu_uop_t mk_uop(input logic [7:0] id, input logic st,
                                                   input int s0, input int dst, input logic hd);
        lsu_iq_pkg::lsu_uop_t u;
        u.id       = id;
        u.is_store = st;
        u.src0     = (s0 < 0) ? free_reg() : lsu_iq_pkg::preg_t'(s0);
        u.src1     = free_reg();
        u.dst      = lsu_iq_pkg::preg_t'(dst);
        u.has_dst  = hd;
        return u;
    endfunction

    function automatic void value_error(input string what, input int exp, input int act);
        errors++;
        $display("Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    endfunction

    // expected issue worked out mid-cycle when outputs are settled
    always @(negedge clk) begin
        logic blocked;
        if (arst_n) begin
            exp_valid = 1'b0;
            exp_idx   = 0;
            blocked   = 1'b0;
            for (int i = 0; i < mq.size() && !lsu_busy; i++) begin
                if (!exp_valid && !blocked && mq[i].src0_rdy && mq[i].src1_rdy) begin
                    exp_valid = 1'b1;
                    exp_idx   = i;
                end
                if (mq[i].uop.is_store) blocked = 1'b1;
            end
            assert (issue_valid == exp_valid)
                else value_error("issue_valid", exp_valid, issue_valid);
            if (exp_valid && issue_valid) begin
                assert (issue_uop == mq[exp_idx].uop)
                    else value_error("issue_uop", mq[exp_idx].uop, issue_uop);
                issued_ids.push_back(issue_uop.id);
            end
            assert (ready == (mq.size() < 7))
                else value_error("ready", mq.size() < 7, ready);
        end
    end

    always @(posedge clk or negedge arst_n) begin
        logic acc;
        lsu_iq_pkg::lsu_entry_t e;
        if (!arst_n) begin
            mq.delete();
            mbusy     = '0;
            exp_valid = 1'b0;
        end else begin
            acc = mq.size() < 7;
            if (flush) begin
                mq.delete();
            end else begin
                foreach (mq[i]) begin
                    mq[i].src0_rdy |= !mbusy[mq[i].uop.src0];
                    mq[i].src1_rdy |= !mbusy[mq[i].uop.src1];
                end
                if (exp_valid) mq.delete(exp_idx);
                if (enq_req_0 && acc) begin
                    e = '{1'b1, enq_uop_0, !mbusy[enq_uop_0.src0], !mbusy[enq_uop_0.src1]};
                    mq.push_back(e);
                end
                if (enq_req_1 && acc) begin
                    e = '{1'b1, enq_uop_1, !mbusy[enq_uop_1.src0], !mbusy[enq_uop_1.src1]};
                    mq.push_back(e);
                end
            end
            if (wb_en_0) mbusy[wb_preg_0] = 1'b0;
            if (wb_en_1) mbusy[wb_preg_1] = 1'b0;
            if (enq_req_0 && acc && enq_uop_0.has_dst) mbusy[enq_uop_0.dst] = 1'b1;
            if (enq_req_1 && acc && enq_uop_1.has_dst) mbusy[enq_uop_1.dst] = 1'b1;
            mbusy[0] = 1'b0;
        end
    end

    task automatic send(input logic r0, input lsu_iq_pkg::lsu_uop_t u0,
                        input logic r1, input lsu_iq_pkg::lsu_uop_t u1);
        @(posedge clk);
        enq_req_0 <= r0;
        enq_uop_0 <= u0;
        enq_req_1 <= r1;
        enq_uop_1 <= u1;
        wb_en_0   <= 1'b0;
        wb_en_1   <= 1'b0;
    endtask

    // port picks writeback port 0 or 1
    task automatic writeback(input int preg, input logic port);
        @(posedge clk);
        enq_req_0 <= 1'b0;
        enq_req_1 <= 1'b0;
        wb_en_0   <= ~port;
        wb_en_1   <= port;
        wb_preg_0 <= lsu_iq_pkg::preg_t'(preg);
        wb_preg_1 <= lsu_iq_pkg::preg_t'(preg);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            enq_req_0 <= 1'b0;
            enq_req_1 <= 1'b0;
            wb_en_0   <= 1'b0;
            wb_en_1   <= 1'b0;
            flush     <= 1'b0;
        end
    endtask

    task automatic wait_ready();
        int n = 0;
        @(negedge clk);
        while (!ready && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            timeouts++;
            $display("%s: ready never came back high", cur_test);
        end
    endtask

    // returns edges waited until the issue count reached cnt
    task automatic wait_issued(input int cnt, output int n);
        n = 0;
        while (issued_ids.size() < cnt && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (issued_ids.size() < cnt) begin
            timeouts++;
            $display("%s: timed out waiting for %0d issues", cur_test, cnt);
        end
    endtask

    task automatic check_ids(input logic [7:0] exp[$]);
        assert (issued_ids.size() == exp.size())
            else value_error("issue count", exp.size(), issued_ids.size());
        for (int i = 0; i < exp.size() && i < issued_ids.size(); i++) begin
            assert (issued_ids[i] == exp[i]) else value_error("issued id", exp[i], issued_ids[i]);
        end
        issued_ids.delete();
    endtask

    task automatic in_order_issue();
        int n;
        lsu_iq_pkg::lsu_uop_t nop = '0;
        cur_test = "in_order";
        assert (!issue_valid) else value_error("issue_valid after reset", 0, issue_valid);
        assert (ready) else value_error("ready after reset", 1, ready);
        for (int i = 0; i < 8; i += 2) begin
            wait_ready();
            if (i < 4) send(1'b1, mk_uop(i, 0, -1, 0, 0), 1'b1, mk_uop(i + 1, 0, -1, 0, 0));
            else begin
                send(1'b1, mk_uop(i, 0, -1, 0, 0), 1'b0, nop);
                send(1'b1, mk_uop(i + 1, 0, -1, 0, 0), 1'b0, nop);
            end
        end
        idle(1);
        wait_issued(8, n);
        idle(3);
        check_ids('{0, 1, 2, 3, 4, 5, 6, 7});
    endtask

    task automatic wakeup_after_writeback();
        int n;
        lsu_iq_pkg::lsu_uop_t nop = '0;
        cur_test = "wakeup";
        send(1'b1, mk_uop(8'h20, 0, -1, 10, 1), 1'b0, nop);
        send(1'b1, mk_uop(8'h21, 0, 10, 0, 0), 1'b0, nop);
        send(1'b1, mk_uop(8'h22, 0, -1, 0, 0), 1'b1, mk_uop(8'h23, 0, -1, 0, 0));
        idle(1);
        wait_issued(3, n);
        idle(4);
        writeback(10, 1'b0);
        idle(1);
        wait_issued(4, n);
        assert (n >= 2) else begin
            errors++;
            $display("%s: waiting load issued too soon after writeback", cur_test);
        end
        check_ids('{8'h20, 8'h22, 8'h23, 8'h21});
    endtask

    task automatic store_blocks_loads();
        int n;
        lsu_iq_pkg::lsu_uop_t nop = '0;
        cur_test = "store_order";
        send(1'b1, mk_uop(8'h31, 0, -1, 12, 1), 1'b0, nop);
        send(1'b1, mk_uop(8'h30, 1, 12, 0, 0), 1'b1, mk_uop(8'h32, 0, -1, 0, 0));
        idle(6);
        assert (issued_ids.size() == 1) else value_error("issues before writeback", 1,
                                                        issued_ids.size());
        writeback(12, 1'b1);
        idle(1);
        wait_issued(3, n);
        check_ids('{8'h31, 8'h30, 8'h32});
    endtask

    task automatic backpressure_fill();
        int n;
        lsu_iq_pkg::lsu_uop_t nop = '0;
        cur_test = "backpressure";
        @(posedge clk) lsu_busy <= 1'b1;
        for (int i = 0; i < 6; i += 2) begin
            send(1'b1, mk_uop(8'h40 + i, 0, -1, 0, 0), 1'b1, mk_uop(8'h41 + i, 0, -1, 0, 0));
        end
        send(1'b1, mk_uop(8'h46, 0, -1, 0, 0), 1'b0, nop);
        send(1'b1, mk_uop(8'h47, 0, -1, 0, 0), 1'b1, mk_uop(8'h48, 0, -1, 0, 0));
        idle(3);
        assert (!ready) else value_error("ready with seven queued", 0, ready);
        assert (issued_ids.size() == 0) else value_error("issues under back-pressure", 0,
                                                        issued_ids.size());
        @(posedge clk) lsu_busy <= 1'b0;
        wait_issued(7, n);
        idle(4);
        check_ids('{8'h40, 8'h41, 8'h42, 8'h43, 8'h44, 8'h45, 8'h46});
    endtask

    task automatic dst_busy_wakeup();
        int n;
        lsu_iq_pkg::lsu_uop_t nop = '0;
        cur_test = "dst_busy";
        send(1'b1, mk_uop(8'h50, 0, -1, 20, 1), 1'b0, nop);
        send(1'b1, mk_uop(8'h51, 1, 20, 0, 0), 1'b0, nop);
        idle(6);
        assert (issued_ids.size() == 1) else value_error("issues before writeback", 1,
                                                        issued_ids.size());
        writeback(20, 1'b0);
        idle(1);
        wait_issued(2, n);
        check_ids('{8'h50, 8'h51});
    endtask

    task automatic flush_empties_queue();
        int n;
        lsu_iq_pkg::lsu_uop_t nop = '0;
        cur_test = "flush";
        @(posedge clk) lsu_busy <= 1'b1;
        for (int i = 0; i < 6; i += 2) begin
            send(1'b1, mk_uop(8'h60 + i, 0, -1, 0, 0), 1'b1, mk_uop(8'h61 + i, 0, -1, 0, 0));
        end
        send(1'b1, mk_uop(8'h66, 0, -1, 0, 0), 1'b0, nop);
        idle(1);
        @(negedge clk);
        assert (!ready) else value_error("ready before flush", 0, ready);
        @(posedge clk) flush <= 1'b1;
        idle(1);
        lsu_busy <= 1'b0;   // queue must already be empty in the cycle after flush
        idle(6);
        assert (issued_ids.size() == 0) else value_error("issues after flush", 0,
                                                        issued_ids.size());
        send(1'b1, mk_uop(8'h68, 0, -1, 0, 0), 1'b0, nop);
        idle(1);
        wait_issued(1, n);
        wait_ready();
        check_ids('{8'h68});
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        flush     = 1'b0;
        enq_req_0 = 1'b0;
        enq_req_1 = 1'b0;
        enq_uop_0 = '0;
        enq_uop_1 = '0;
        wb_en_0   = 1'b0;
        wb_en_1   = 1'b0;
        wb_preg_0 = '0;
        wb_preg_1 = '0;
        lsu_busy  = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        in_order_issue();
        wakeup_after_writeback();
        store_blocks_loads();
        backpressure_fill();
        dst_busy_wakeup();
        flush_empties_queue();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
verilog/lsu_iq_pkg.sv
verilog/lsu_iq_entry.sv
verilog/lsu_iq.sv
verilog/lsu_issue_pick.sv
verilog/lsu_busy_table.sv
verilog/lsu_issue_unit.sv
tb/lsu_issue_unit_checker.sv
tb/lsu_issue_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= lsu_issue_unit_tb
FILELIST  ?= all.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep -qF "Test OK"

clean:
	rm -rf $(OBJ_DIR)
